// File: sim.f
mpf_pkg.sv
wr_hdr_if.sv
write_data_heap.sv
afu_write_edge.sv
hdr_fifo.sv
fiu_write_edge.sv
edge_connect_top.sv
tb_edge_connect_props.sv
tb_edge_connect.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the edge connector testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_edge_connect

status=0
./obj_dir/Vtb_edge_connect > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation passed"

// File: tb_edge_connect.sv
// Testbench for the write path edge connector that sends random multi-beat
// packets from the AFU side and checks each beat against a reference queue
`timescale 1ns/1ns
`default_nettype none

module tb_edge_connect import mpf_pkg::*;
    ();

    localparam int CLK_PERIOD = 8;
    localparam int NUM_PACKETS = 300;
    localparam int CYCLES_PER_PACKET = 40;
    localparam int unsigned SEED = 32'h2651b3d5;

    logic clk;
    logic reset;
    logic afu_wr_valid;
    logic afu_wr_sop;
    cl_addr_t afu_wr_addr;
    cl_len_t afu_wr_cl_len;
    cl_data_t afu_wr_data;
    logic afu_almost_full;
    logic fiu_almost_full;
    logic fiu_wr_valid;
    logic fiu_wr_sop;
    cl_addr_t fiu_wr_addr;
    cl_len_t fiu_wr_cl_len;
    cl_data_t fiu_wr_data;

    // Reference model with one entry per beat expected at the FIU side
    cl_addr_t exp_addr [$];
    cl_data_t exp_data [$];
    cl_len_t exp_len [$];
    logic exp_sop [$];
    // Set once the FIU stalls have backed up far enough to hold off the AFU
    logic afu_bp_seen;

    edge_connect_top dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================================================
    // Failure reporting and compare tasks
    // ========================================================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name, input cl_addr_t got, input cl_addr_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_data(input string name, input cl_data_t got, input cl_data_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_len(input string name, input cl_len_t got, input cl_len_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================

    // Beats mostly follow back to back, with now and then a long hole inside a packet
    function automatic int unsigned pick_gap();
        int unsigned sel;
        sel = $urandom % 16;
        if (sel == 0)
            return 10 + $urandom % 30;
        else if (sel < 4)
            return 1 + $urandom % 3;
        return 0;
    endfunction

    task automatic send_packet(input cl_addr_t base, input cl_len_t len);
        cl_data_t data;
        int unsigned gap;
        // The bus is idle here, so back-pressure seen low in this cycle
        // can only stay low in the next one, where the first beat goes out
        @(negedge clk);
        while (afu_almost_full)
        begin
            @(negedge clk);
        end
        for (int b = 0; b <= int'(len); b++)
        begin
            if (b != 0)
            begin
                gap = pick_gap();
                repeat (gap)
                begin
                    @(posedge clk);
                    afu_wr_valid <= 1'b0;
                end
            end
            data = {$urandom, $urandom};
            @(posedge clk);
            afu_wr_valid <= 1'b1;
            afu_wr_sop <= (b == 0);
            afu_wr_addr <= base | cl_addr_t'(b);
            afu_wr_cl_len <= len;
            afu_wr_data <= data;
            // Each beat is rebuilt with the packet address ORed with its number
            exp_addr.push_back(base | cl_addr_t'(b));
            exp_data.push_back(data);
            exp_len.push_back(len);
            exp_sop.push_back(b == 0);
        end
        @(posedge clk);
        afu_wr_valid <= 1'b0;
    endtask

    initial
    begin : main_flow
        cl_addr_t base;
        cl_len_t len;
        clk = 1'b0;
        reset = 1'b1;
        afu_wr_valid = 1'b0;
        afu_wr_sop = 1'b0;
        afu_wr_addr = '0;
        afu_wr_cl_len = '0;
        afu_wr_data = '0;
        fiu_almost_full = 1'b0;
        afu_bp_seen = 1'b0;
        void'($urandom(SEED));

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        for (int p = 0; p < NUM_PACKETS; p++)
        begin
            // Aligned to four lines so the beat number fits in the low bits
            base = cl_addr_t'($urandom & 32'hffff_fffc);
            len = cl_len_t'($urandom % 4);
            send_packet(base, len);
        end

        while (exp_addr.size() != 0)
        begin
            @(posedge clk);
        end
        // A few more cycles to catch stray or duplicated beats
        repeat (20) @(posedge clk);

        if (!afu_bp_seen)
            abort_run("The long FIU stalls never raised back-pressure on the AFU side");
        else
        begin
            $display("Test OK");
            $finish;
        end
    end

    // FIU back-pressure mixes short random blips with occasional long stalls
    // that back the FIFO and heap up to the AFU side
    initial
    begin : fiu_backpressure
        int unsigned hold;
        hold = 0;
        @(negedge reset);
        forever
        begin
            @(posedge clk);
            if (hold != 0)
                hold = hold - 1;
            else if ($urandom % 150 == 0)
            begin
                hold = 60 + $urandom % 100;
                fiu_almost_full <= 1'b1;
            end
            else
                fiu_almost_full <= ($urandom % 4 == 0);
        end
    end

    // ========================================================================
    // Output monitor and watchdog
    // ========================================================================

    always @(negedge clk)
    begin
        if (!reset && afu_almost_full)
            afu_bp_seen = 1'b1;
        if (!reset && fiu_wr_valid)
        begin
            if (exp_addr.size() == 0)
                abort_run("An FIU write beat appeared with no AFU beat outstanding");
            else
            begin
                check_bit("fiu_wr_sop", fiu_wr_sop, exp_sop.pop_front());
                check_addr("fiu_wr_addr", fiu_wr_addr, exp_addr.pop_front());
                check_len("fiu_wr_cl_len", fiu_wr_cl_len, exp_len.pop_front());
                check_data("fiu_wr_data", fiu_wr_data, exp_data.pop_front());
            end
        end
    end

    initial
    begin : watchdog
        #(NUM_PACKETS * CYCLES_PER_PACKET * CLK_PERIOD);
        abort_run("Timeout, the packets did not drain through the FIU side in time");
    end

endmodule

`default_nettype wire

// File: tb_edge_connect_props.sv
// Bound checks on the edge connector for reset values, output packet
// framing and both back-pressure paths
`timescale 1ns/1ns
`default_nettype none

module tb_edge_connect_props import mpf_pkg::*;
    (
    input logic clk,
    input logic reset,
    input logic afu_wr_valid,
    input logic afu_wr_sop,
    input cl_len_t afu_wr_cl_len,
    input logic afu_almost_full,
    input logic fiu_almost_full,
    input logic fiu_wr_valid,
    input logic fiu_wr_sop,
    input cl_len_t fiu_wr_cl_len
    );

    // Beats still owed by the open packet on each side
    cl_len_t afu_rem;
    cl_len_t fiu_rem;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            afu_rem <= '0;
            fiu_rem <= '0;
        end
        else
        begin
            if (afu_wr_valid)
                afu_rem <= afu_wr_sop ? afu_wr_cl_len : afu_rem - 1'b1;
            // With nothing owed, the next FIU beat opens a new packet
            if (fiu_wr_valid)
                fiu_rem <= (fiu_rem == '0) ? fiu_wr_cl_len : fiu_rem - 1'b1;
        end
    end

    reset_outputs_low: assert property (@(posedge clk)
        reset |=> !fiu_wr_valid && !afu_almost_full)
        else $error("Outputs not low after reset");

    first_beat_has_sop: assert property (@(posedge clk) disable iff (reset)
        fiu_wr_valid && (fiu_rem == '0) |-> fiu_wr_sop)
        else $error("First FIU beat of a packet without sop");

    no_afu_backpressure_mid_packet: assert property (@(posedge clk) disable iff (reset)
        (afu_rem != '0) |-> !afu_almost_full)
        else $error("AFU back-pressure raised inside a packet");

    // Stages 2 and 3 may still drain, nothing more after that
    fiu_stall_limit: assert property (@(posedge clk) disable iff (reset)
        fiu_almost_full && $past(fiu_almost_full) && $past(fiu_almost_full, 2)
        |-> !fiu_wr_valid)
        else $error("FIU beat emitted three cycles into a stall");

endmodule

bind edge_connect_top tb_edge_connect_props props (
    .clk(clk),
    .reset(reset),
    .afu_wr_valid(afu_wr_valid),
    .afu_wr_sop(afu_wr_sop),
    .afu_wr_cl_len(afu_wr_cl_len),
    .afu_almost_full(afu_almost_full),
    .fiu_almost_full(fiu_almost_full),
    .fiu_wr_valid(fiu_wr_valid),
    .fiu_wr_sop(fiu_wr_sop),
    .fiu_wr_cl_len(fiu_wr_cl_len)
);

`default_nettype wire

// File: edge_connect_top.sv
// Write path edge connector, AFU edge to header FIFO to FIU edge, with the
// beat data held in a shared heap
`timescale 1ns/1ns
`default_nettype none

module edge_connect_top import mpf_pkg::*;
    (
    input logic clk,
    input logic reset,

    // AFU side
    input logic afu_wr_valid,
    input logic afu_wr_sop,
    input cl_addr_t afu_wr_addr,
    input cl_len_t afu_wr_cl_len,
    input cl_data_t afu_wr_data,
    output logic afu_almost_full,

    // FIU side
    input logic fiu_almost_full,
    output logic fiu_wr_valid,
    output logic fiu_wr_sop,
    output cl_addr_t fiu_wr_addr,
    output cl_len_t fiu_wr_cl_len,
    output cl_data_t fiu_wr_data
    );

    logic heap_enq;
    cl_data_t heap_enq_data;
    logic heap_not_full;
    heap_idx_t heap_alloc_idx;
    heap_idx_t heap_read_idx;
    cl_data_t heap_read_data;
    logic heap_free;
    heap_idx_t heap_free_idx;
    logic fifo_almost_full;
    logic fifo_deq;

    // Headers entering and leaving the FIFO
    wr_hdr_if afu_hdr ();
    wr_hdr_if fiu_hdr ();

    write_data_heap u_heap (
        .clk(clk),
        .reset(reset),
        .enq(heap_enq),
        .enq_data(heap_enq_data),
        .not_full(heap_not_full),
        .alloc_idx(heap_alloc_idx),
        .read_idx(heap_read_idx),
        .read_data(heap_read_data),
        .free(heap_free),
        .free_idx(heap_free_idx)
    );

    afu_write_edge u_afu_edge (
        .clk(clk),
        .reset(reset),
        .wr_valid(afu_wr_valid),
        .wr_sop(afu_wr_sop),
        .wr_addr(afu_wr_addr),
        .wr_cl_len(afu_wr_cl_len),
        .wr_data(afu_wr_data),
        .almost_full(afu_almost_full),
        .heap_not_full(heap_not_full),
        .alloc_idx(heap_alloc_idx),
        .heap_enq(heap_enq),
        .heap_enq_data(heap_enq_data),
        .hdr(afu_hdr.source),
        .fifo_almost_full(fifo_almost_full)
    );

    hdr_fifo u_hdr_fifo (
        .clk(clk),
        .reset(reset),
        .in_hdr(afu_hdr.sink),
        .almost_full(fifo_almost_full),
        .out_hdr(fiu_hdr.source),
        .deq(fifo_deq)
    );

    fiu_write_edge u_fiu_edge (
        .clk(clk),
        .reset(reset),
        .hdr(fiu_hdr.sink),
        .deq(fifo_deq),
        .alloc_idx(heap_alloc_idx),
        .read_idx(heap_read_idx),
        .read_data(heap_read_data),
        .free(heap_free),
        .free_idx(heap_free_idx),
        .fiu_almost_full(fiu_almost_full),
        .wr_valid(fiu_wr_valid),
        .wr_sop(fiu_wr_sop),
        .wr_addr(fiu_wr_addr),
        .wr_cl_len(fiu_wr_cl_len),
        .wr_data(fiu_wr_data)
    );

endmodule

`default_nettype wire

// File: fiu_write_edge.sv
// FIU edge of the write path, rebuilds multi-beat writes from one header
// and merges the beat data read back from the heap
`timescale 1ns/1ns
`default_nettype none

module fiu_write_edge import mpf_pkg::*;
    (
    input logic clk,
    input logic reset,

    wr_hdr_if.sink hdr,
    output logic deq,

    // Heap read and release
    input heap_idx_t alloc_idx,
    output heap_idx_t read_idx,
    input cl_data_t read_data,
    output logic free,
    output heap_idx_t free_idx,

    // Rebuilt write beats toward the FIU
    input logic fiu_almost_full,
    output logic wr_valid,
    output logic wr_sop,
    output cl_addr_t wr_addr,
    output cl_len_t wr_cl_len,
    output cl_data_t wr_data
    );

    beat_state_t state;
    cl_addr_t s1_addr;
    cl_len_t s1_cl_len;
    logic s1_sop;
    cl_len_t s1_beat_idx;
    cl_len_t s1_beats_rem;
    logic data_rdy;
    logic may_fire;
    logic packet_done;

    logic s2_valid;
    logic s2_sop;
    cl_addr_t s2_addr;
    cl_len_t s2_cl_len;

    // ========================================================================
    // Stage 1, beat generator
    // ========================================================================

    assign may_fire = (state == BEAT_EMIT) && data_rdy && !fiu_almost_full;
    assign packet_done = may_fire && (s1_beats_rem == '0);
    // Take a new header when idle or when the last beat leaves this cycle
    assign deq = hdr.valid && (packet_done || state == BEAT_IDLE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= BEAT_IDLE;
            data_rdy <= 1'b0;
        end
        else if (deq)
        begin
            state <= BEAT_EMIT;
            // First beat's data went into the heap with the header
            data_rdy <= 1'b1;
        end
        else if (packet_done)
        begin
            state <= BEAT_IDLE;
            data_rdy <= 1'b0;
        end
        else if (may_fire)
        begin
            // The next slot is ready once the heap has moved past it
            data_rdy <= (read_idx + 1'b1) != alloc_idx;
        end
        else
        begin
            data_rdy <= (state == BEAT_EMIT) && (read_idx != alloc_idx);
        end
    end

    // Header fields and beat counters
    always_ff @(posedge clk)
    begin
        if (deq)
        begin
            s1_addr <= hdr.addr;
            s1_cl_len <= hdr.cl_len;
            s1_sop <= 1'b1;
            s1_beat_idx <= '0;
            s1_beats_rem <= hdr.cl_len;
            read_idx <= hdr.heap_idx;
        end
        else if (may_fire)
        begin
            s1_sop <= 1'b0;
            s1_beat_idx <= s1_beat_idx + 1'b1;
            s1_beats_rem <= s1_beats_rem - 1'b1;
            read_idx <= read_idx + 1'b1;
        end
    end

    // ========================================================================
    // Stages 2 and 3, heap release and data merge
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free <= 1'b0;
            s2_valid <= 1'b0;
            wr_valid <= 1'b0;
        end
        else
        begin
            // Release the slot one cycle after its read is issued
            free <= may_fire;
            s2_valid <= may_fire;
            wr_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        free_idx <= read_idx;
        s2_sop <= s1_sop;
        // Aligned packet, so ORing the beat number gives the beat address
        s2_addr <= s1_addr | cl_addr_t'(s1_beat_idx);
        s2_cl_len <= s1_cl_len;

        wr_sop <= s2_sop;
        wr_addr <= s2_addr;
        wr_cl_len <= s2_cl_len;
    end

    // Heap data arrives two cycles after the read, aligned with stage 3
    assign wr_data = read_data;

endmodule

`default_nettype wire

// File: hdr_fifo.sv
// Header FIFO standing in for the request pipeline between the edges,
// with an almost-full level for back-pressure
`timescale 1ns/1ns
`default_nettype none

module hdr_fifo import mpf_pkg::*;
    (
    input logic clk,
    input logic reset,

    wr_hdr_if.sink in_hdr,
    output logic almost_full,

    // Oldest entry, valid whenever the FIFO holds something
    wr_hdr_if.source out_hdr,
    input logic deq
    );

    cl_addr_t addr_q [HDR_FIFO_ENTRIES];
    cl_len_t cl_len_q [HDR_FIFO_ENTRIES];
    heap_idx_t heap_idx_q [HDR_FIFO_ENTRIES];

    fifo_idx_t wr_ptr;
    fifo_idx_t rd_ptr;
    fifo_cnt_t count;

    assign almost_full = (HDR_FIFO_ENTRIES - int'(count)) <= ALMOST_FULL_THRESHOLD;

    assign out_hdr.valid = (count != '0);
    assign out_hdr.addr = addr_q[rd_ptr];
    assign out_hdr.cl_len = cl_len_q[rd_ptr];
    assign out_hdr.heap_idx = heap_idx_q[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            // The sender never pushes past the almost-full level
            if (in_hdr.valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (deq)
                rd_ptr <= rd_ptr + 1'b1;

            if (in_hdr.valid && !deq)
                count <= count + 1'b1;
            else if (!in_hdr.valid && deq)
                count <= count - 1'b1;
        end
    end

    // Entry storage
    always_ff @(posedge clk)
    begin
        if (in_hdr.valid)
        begin
            addr_q[wr_ptr] <= in_hdr.addr;
            cl_len_q[wr_ptr] <= in_hdr.cl_len;
            heap_idx_q[wr_ptr] <= in_hdr.heap_idx;
        end
    end

endmodule

`default_nettype wire

// File: afu_write_edge.sv
// AFU edge of the write path, parks every beat in the heap and sends
// only the start-of-packet header onward
`timescale 1ns/1ns
`default_nettype none

module afu_write_edge import mpf_pkg::*;
    (
    input logic clk,
    input logic reset,

    // Write beats from the AFU
    input logic wr_valid,
    input logic wr_sop,
    input cl_addr_t wr_addr,
    input cl_len_t wr_cl_len,
    input cl_data_t wr_data,
    output logic almost_full,

    // Heap allocation
    input logic heap_not_full,
    input heap_idx_t alloc_idx,
    output logic heap_enq,
    output cl_data_t heap_enq_data,

    // Header channel toward the FIFO
    wr_hdr_if.source hdr,
    input logic fifo_almost_full
    );

    // Beats still owed by the packet in progress
    cl_len_t beats_rem;
    logic packet_active;

    assign packet_active = (beats_rem != '0);

    // Every beat's data lands in the heap, first beat included
    assign heap_enq = wr_valid;
    assign heap_enq_data = wr_data;

    // Only the header travels through the FIFO. It carries the heap slot of
    // its first beat instead of the data itself
    assign hdr.valid = wr_valid && wr_sop;
    assign hdr.addr = wr_addr;
    assign hdr.cl_len = wr_cl_len;
    assign hdr.heap_idx = alloc_idx;

    // Back-pressure is held off while a packet is open. The header is
    // already in the FIFO, so stopping the trailing beats would deadlock
    assign almost_full = (fifo_almost_full || !heap_not_full) && !packet_active;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beats_rem <= '0;
        end
        else if (wr_valid)
        begin
            // A start of packet loads the count, each later beat uses one up
            if (wr_sop)
                beats_rem <= wr_cl_len;
            else
                beats_rem <= beats_rem - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: write_data_heap.sv
// Write data heap, a circular buffer that hands out slots in order,
// reads with two cycles of latency and releases slots in order
`timescale 1ns/1ns
`default_nettype none

module write_data_heap import mpf_pkg::*;
    (
    input logic clk,
    input logic reset,

    input logic enq,
    input cl_data_t enq_data,
    output logic not_full,
    output heap_idx_t alloc_idx,

    input heap_idx_t read_idx,
    output cl_data_t read_data,

    input logic free,
    input heap_idx_t free_idx
    );

    cl_data_t mem [HEAP_ENTRIES];

    // Next slot to be written
    heap_idx_t tail_idx;
    // Oldest slot still holding live data
    heap_idx_t head_idx;
    heap_idx_t used_count;
    heap_idx_t read_addr_q;

    // The reserve keeps the heap from ever filling completely, so the
    // pointer difference alone gives the occupancy without wrap ambiguity
    assign used_count = tail_idx - head_idx;
    assign not_full = (int'(used_count) + HEAP_MIN_FREE) <= HEAP_ENTRIES;
    assign alloc_idx = tail_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tail_idx <= '0;
            head_idx <= '0;
        end
        else
        begin
            if (enq)
            begin
                tail_idx <= tail_idx + 1'b1;
            end

            // Slots are released in order, so the head moves just past the
            // slot being freed and the occupancy drops by one
            if (free)
            begin
                head_idx <= free_idx + 1'b1;
            end
        end
    end

    // Data is written in the same cycle it arrives
    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            mem[tail_idx] <= enq_data;
        end
    end

    // Two-stage read, an address register followed by an output register
    always_ff @(posedge clk)
    begin
        read_addr_q <= read_idx;
        read_data <= mem[read_addr_q];
    end

endmodule

`default_nettype wire

// File: wr_hdr_if.sv
// Write header channel, one start-of-packet header with the heap slot
// that holds its first beat of data
`timescale 1ns/1ns
`default_nettype none

interface wr_hdr_if import mpf_pkg::*;
    ();

    logic valid;
    cl_addr_t addr;
    cl_len_t cl_len;
    // Heap slot of the first beat, later beats follow in consecutive slots
    heap_idx_t heap_idx;

    modport source (output valid, output addr, output cl_len, output heap_idx);

    modport sink (input valid, input addr, input cl_len, input heap_idx);

endinterface

`default_nettype wire

// File: mpf_pkg.sv
// Shared widths, sizes and flow-control thresholds for the write path
// between the AFU edge and the FIU edge
`default_nettype none

package mpf_pkg;

    // ========================================================================
    // Sizes and thresholds
    // ========================================================================

    // Write data heap depth, one slot per cache-line beat
    localparam int HEAP_ENTRIES = 32;

    // Longest multi-beat write packet
    localparam int MAX_BEATS = 4;

    // Header FIFO depth between the two edges
    localparam int HDR_FIFO_ENTRIES = 8;

    // A buffer reports almost full when this many slots or fewer are free
    localparam int ALMOST_FULL_THRESHOLD = 2;

    // Heap reserve so that a packet already under way can always finish
    localparam int HEAP_MIN_FREE = ALMOST_FULL_THRESHOLD + MAX_BEATS + 1;

    localparam int HEAP_IDX_BITS = $clog2(HEAP_ENTRIES);
    localparam int FIFO_IDX_BITS = $clog2(HDR_FIFO_ENTRIES);

    // ========================================================================
    // Types
    // ========================================================================

    typedef logic [31:0] cl_addr_t;
    typedef logic [63:0] cl_data_t;
    // Number of beats in a packet minus one
    typedef logic [1:0] cl_len_t;
    typedef logic [HEAP_IDX_BITS-1:0] heap_idx_t;
    typedef logic [FIFO_IDX_BITS-1:0] fifo_idx_t;
    // One extra bit so a full FIFO can be told from an empty one
    typedef logic [FIFO_IDX_BITS:0] fifo_cnt_t;

    // Output side beat generator
    typedef enum logic {BEAT_IDLE, BEAT_EMIT} beat_state_t;

endpackage

`default_nettype wire
